//--- Bender.yml
package:
  name: ppu_tile_frontend

export_include_dirs:
  - .

sources:
  - ppu_tile_pkg.sv
  - ppu_ctrl_pkg.sv
  - tcam_tile_store.sv
  - subset_detector.sv
  - prefix_pruner.sv
  - task_dispatcher.sv
  - tile_sequencer.sv
  - ppu_top.sv
  - target: test
    files:
      - tb_ppu_top.sv

//--- ppu_ctrl_pkg.sv
`include "ppu_params.svh"

package ppu_ctrl_pkg;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE    = 2'd0, // Waiting for tile_start
    PROCESS = 2'd1, // Issuing rows
    DRAIN   = 2'd2 // Last row issued, waiting for tile_done
  } seq_state_t;

  // Occupancy 0..depth, reserved slots included
  typedef logic [$clog2(`PPU_FIFO_DEPTH + 1)-1:0] fifo_count_t;

endpackage

//--- ppu_params.svh
`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// ==============================
// Tile geometry
// ==============================
`define PPU_ROWS 16 // Rows per tile
`define PPU_SPIKES 16 // Spikes per pattern

// Derived widths
`define PPU_ROW_W 4 // log2(PPU_ROWS)
`define PPU_PC_W 5 // Holds 0..PPU_SPIKES

// ==============================
// Dispatcher
// ==============================
// Power of two, pointers wrap naturally
`define PPU_FIFO_DEPTH 4

`endif

//--- ppu_tile_pkg.sv
`include "ppu_params.svh"

package ppu_tile_pkg;

  typedef logic [`PPU_SPIKES-1:0] pattern_t; // One spike pattern
  typedef logic [`PPU_ROW_W-1:0] row_id_t; // Row index
  typedef logic [`PPU_PC_W-1:0] popcount_t; // Ones in a pattern
  typedef logic [`PPU_ROWS-1:0] subset_vec_t; // One candidate flag per row

  // Ones count, shared by the store and the pruner
  function automatic popcount_t count_ones(input pattern_t pat);
    popcount_t n;
    n = '0;
    for (int i = 0; i < `PPU_SPIKES; i++) begin
      n = n + popcount_t'(pat[i]);
    end
    return n;
  endfunction

endpackage

//--- ppu_top.sv
`timescale 1ns/10ps
`include "ppu_params.svh"

module ppu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Host write and read port
  input  logic                   tile_wr_en,
  input  logic [`PPU_ROW_W-1:0]  tile_wr_addr,
  input  logic [`PPU_SPIKES-1:0] tile_wr_data,
  input  logic [`PPU_ROW_W-1:0]  tile_rd_addr,
  output logic [`PPU_SPIKES-1:0] tile_rd_data,
  output logic [`PPU_PC_W-1:0]   popcount_rd_data,
  // Control
  input  logic                   tile_start,
  input  logic                   cfg_auto_repeat,
  output logic                   ppu_busy,
  output logic                   tile_done,
  // Compute-core task port
  output logic                   task_valid,
  input  logic                   task_ready,
  output logic [`PPU_ROW_W-1:0]  task_row_id,
  output logic [`PPU_ROW_W-1:0]  task_prefix_id,
  output logic                   task_root,
  output logic [`PPU_SPIKES-1:0] task_pattern,
  output logic [`PPU_PC_W-1:0]   task_popcount
);

  // ==============================
  // Internal wiring
  // ==============================
  logic [`PPU_SPIKES-1:0] row_patterns [`PPU_ROWS];
  logic [`PPU_PC_W-1:0]   row_popcounts [`PPU_ROWS];

  logic                  issue_valid;
  logic                  issue_allow;
  logic [`PPU_ROW_W-1:0] issue_row_id;

  logic                   det_valid; // Stage 1
  logic [`PPU_ROW_W-1:0]  det_row_id;
  logic [`PPU_SPIKES-1:0] det_pattern;
  logic [`PPU_ROWS-1:0]   det_subset;

  logic                   prn_valid; // Stage 2
  logic [`PPU_ROW_W-1:0]  prn_row_id;
  logic                   prn_root;
  logic [`PPU_ROW_W-1:0]  prn_prefix_id;
  logic [`PPU_SPIKES-1:0] prn_residual;
  logic [`PPU_PC_W-1:0]   prn_residual_pc;

  tcam_tile_store u_store (
    .clk              (clk),
    .rst_n            (rst_n),
    .tile_wr_en       (tile_wr_en),
    .tile_wr_addr     (tile_wr_addr),
    .tile_wr_data     (tile_wr_data),
    .tile_rd_addr     (tile_rd_addr),
    .tile_rd_data     (tile_rd_data),
    .popcount_rd_data (popcount_rd_data),
    .row_patterns     (row_patterns),
    .row_popcounts    (row_popcounts)
  );

  tile_sequencer u_sequencer (
    .clk             (clk),
    .rst_n           (rst_n),
    .tile_start      (tile_start),
    .cfg_auto_repeat (cfg_auto_repeat),
    .issue_allow     (issue_allow),
    .tile_done       (tile_done),
    .issue_valid     (issue_valid),
    .issue_row_id    (issue_row_id),
    .ppu_busy        (ppu_busy)
  );

  subset_detector u_detector (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid   (issue_valid),
    .issue_row_id  (issue_row_id),
    .row_patterns  (row_patterns),
    .row_popcounts (row_popcounts),
    .det_valid     (det_valid),
    .det_row_id    (det_row_id),
    .det_pattern   (det_pattern),
    .det_subset    (det_subset)
  );

  prefix_pruner u_pruner (
    .clk             (clk),
    .rst_n           (rst_n),
    .det_valid       (det_valid),
    .det_row_id      (det_row_id),
    .det_pattern     (det_pattern),
    .det_subset      (det_subset),
    .row_patterns    (row_patterns),
    .row_popcounts   (row_popcounts),
    .prn_valid       (prn_valid),
    .prn_row_id      (prn_row_id),
    .prn_root        (prn_root),
    .prn_prefix_id   (prn_prefix_id),
    .prn_residual    (prn_residual),
    .prn_residual_pc (prn_residual_pc)
  );

  task_dispatcher u_dispatcher (
    .clk             (clk),
    .rst_n           (rst_n),
    .issue_valid     (issue_valid),
    .prn_valid       (prn_valid),
    .prn_row_id      (prn_row_id),
    .prn_root        (prn_root),
    .prn_prefix_id   (prn_prefix_id),
    .prn_residual    (prn_residual),
    .prn_residual_pc (prn_residual_pc),
    .issue_allow     (issue_allow),
    .task_ready      (task_ready),
    .task_valid      (task_valid),
    .task_row_id     (task_row_id),
    .task_prefix_id  (task_prefix_id),
    .task_root       (task_root),
    .task_pattern    (task_pattern),
    .task_popcount   (task_popcount),
    .tile_done       (tile_done)
  );

endmodule

//--- prefix_pruner.sv
`timescale 1ns/10ps
`include "ppu_params.svh"

module prefix_pruner import ppu_tile_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        det_valid,
  input  row_id_t     det_row_id,
  input  pattern_t    det_pattern,
  input  subset_vec_t det_subset,
  input  pattern_t    row_patterns [`PPU_ROWS],
  input  popcount_t   row_popcounts [`PPU_ROWS],
  output logic        prn_valid,
  output row_id_t     prn_row_id,
  output logic        prn_root,
  output row_id_t     prn_prefix_id,
  output pattern_t    prn_residual,
  output popcount_t   prn_residual_pc
);

  logic      best_found; // At least one candidate
  row_id_t   best_id;
  popcount_t best_pc;
  pattern_t  prefix_pat; // XOR operand, zero for a root
  pattern_t  residual;

  // ==============================
  // Best prefix search
  // ==============================
  // Ascending scan with strict compare keeps the lowest index on a tie
  always_comb begin
    best_found = 1'b0;
    best_id    = '0;
    best_pc    = '0;
    for (int r = 0; r < `PPU_ROWS; r++) begin
      if (det_subset[r] && (!best_found || (row_popcounts[r] > best_pc))) begin
        best_found = 1'b1;
        best_id    = row_id_t'(r);
        best_pc    = row_popcounts[r];
      end
    end
  end

  assign prefix_pat = best_found ? row_patterns[best_id] : '0;
  assign residual   = det_pattern ^ prefix_pat; // Spikes still to be computed

  // ==============================
  // Stage 2 register
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prn_valid <= 1'b0;
    end else begin
      prn_valid <= det_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (det_valid) begin
      prn_row_id      <= det_row_id;
      prn_root        <= !best_found;
      prn_prefix_id   <= best_id; // Zero when root
      prn_residual    <= residual;
      prn_residual_pc <= count_ones(residual);
    end
  end

endmodule

//--- project.f
+incdir+.
ppu_tile_pkg.sv
ppu_ctrl_pkg.sv
tcam_tile_store.sv
subset_detector.sv
prefix_pruner.sv
task_dispatcher.sv
tile_sequencer.sv
ppu_top.sv
tb_ppu_top.sv

//--- subset_detector.sv
`timescale 1ns/10ps
`include "ppu_params.svh"

module subset_detector import ppu_tile_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        issue_valid,
  input  row_id_t     issue_row_id,
  input  pattern_t    row_patterns [`PPU_ROWS],
  input  popcount_t   row_popcounts [`PPU_ROWS],
  output logic        det_valid,
  output row_id_t     det_row_id,
  output pattern_t    det_pattern,
  output subset_vec_t det_subset
);

  pattern_t    query_pat; // Pattern of the issued row
  subset_vec_t match; // Candidate flags, one per stored row

  assign query_pat = row_patterns[issue_row_id];

  // TCAM style lookup against every row in parallel
  always_comb begin
    for (int r = 0; r < `PPU_ROWS; r++) begin
      match[r] = (r < int'(issue_row_id)) // Earlier rows only, no cycles
                 && (row_popcounts[r] != '0) // Empty rows give nothing
                 && ((row_patterns[r] & ~query_pat) == '0); // No bit outside the query
    end
  end

  // Stage 1 register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      det_valid <= 1'b0;
    end else begin
      det_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      det_row_id  <= issue_row_id;
      det_pattern <= query_pat;
      det_subset  <= match;
    end
  end

endmodule

//--- task_dispatcher.sv
`timescale 1ns/10ps
`include "ppu_params.svh"

module task_dispatcher import ppu_tile_pkg::*, ppu_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      issue_valid, // Reserves a slot
  // From the pruner
  input  logic      prn_valid,
  input  row_id_t   prn_row_id,
  input  logic      prn_root,
  input  row_id_t   prn_prefix_id,
  input  pattern_t  prn_residual,
  input  popcount_t prn_residual_pc,
  // Flow control back to the sequencer
  output logic      issue_allow,
  // Compute-core port
  input  logic      task_ready,
  output logic      task_valid,
  output row_id_t   task_row_id,
  output row_id_t   task_prefix_id,
  output logic      task_root,
  output pattern_t  task_pattern,
  output popcount_t task_popcount,
  output logic      tile_done
);

  localparam int PTR_W = $clog2(`PPU_FIFO_DEPTH);

  // ==============================
  // FIFO storage, one array per field
  // ==============================
  row_id_t   fifo_row [`PPU_FIFO_DEPTH];
  row_id_t   fifo_prefix [`PPU_FIFO_DEPTH];
  logic      fifo_root [`PPU_FIFO_DEPTH];
  pattern_t  fifo_pat [`PPU_FIFO_DEPTH];
  popcount_t fifo_pc [`PPU_FIFO_DEPTH];

  logic [PTR_W:0] wr_ptr; // Extra bit tells full from empty
  logic [PTR_W:0] rd_ptr;
  fifo_count_t    res_count; // Stored plus in flight
  logic           xfer;

  assign xfer        = task_valid && task_ready;
  assign issue_allow = res_count < fifo_count_t'(`PPU_FIFO_DEPTH);

  // Pruner output never finds the FIFO full, its slot was reserved at issue
  always_ff @(posedge clk) begin
    if (prn_valid) begin
      fifo_row[wr_ptr[PTR_W-1:0]]    <= prn_row_id;
      fifo_prefix[wr_ptr[PTR_W-1:0]] <= prn_prefix_id;
      fifo_root[wr_ptr[PTR_W-1:0]]   <= prn_root;
      fifo_pat[wr_ptr[PTR_W-1:0]]    <= prn_residual;
      fifo_pc[wr_ptr[PTR_W-1:0]]     <= prn_residual_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      res_count <= '0;
    end else begin
      if (prn_valid) wr_ptr <= wr_ptr + 1'b1;
      if (xfer) rd_ptr <= rd_ptr + 1'b1;
      // Up on issue, down on transfer, both may happen together
      res_count <= res_count + fifo_count_t'(issue_valid) - fifo_count_t'(xfer);
    end
  end

  // ==============================
  // Head of FIFO to the core
  // ==============================
  // Head only moves on a transfer so valid and data hold while stalled
  assign task_valid     = wr_ptr != rd_ptr;
  assign task_row_id    = fifo_row[rd_ptr[PTR_W-1:0]];
  assign task_prefix_id = fifo_prefix[rd_ptr[PTR_W-1:0]];
  assign task_root      = fifo_root[rd_ptr[PTR_W-1:0]];
  assign task_pattern   = fifo_pat[rd_ptr[PTR_W-1:0]];
  assign task_popcount  = fifo_pc[rd_ptr[PTR_W-1:0]];

  // Pulse after the last row of the tile leaves
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tile_done <= 1'b0;
    end else begin
      tile_done <= xfer && (task_row_id == row_id_t'(`PPU_ROWS - 1));
    end
  end

endmodule

//--- tb_ppu_top.sv
`timescale 1ns/10ps
`include "ppu_params.svh"

module tb_ppu_top import ppu_tile_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int N_TESTS    = 5;
  localparam int MAX_PASSES = 2; // Auto-repeat runs two passes
  localparam int WATCHDOG_NS = N_TESTS * MAX_PASSES * `PPU_ROWS * 8 * CLK_PERIOD + 4000;

  logic      clk;
  logic      rst_n;
  logic      tile_wr_en;
  row_id_t   tile_wr_addr;
  pattern_t  tile_wr_data;
  row_id_t   tile_rd_addr;
  pattern_t  tile_rd_data;
  popcount_t popcount_rd_data;
  logic      tile_start;
  logic      cfg_auto_repeat;
  logic      ppu_busy;
  logic      tile_done;
  logic      task_valid;
  logic      task_ready;
  row_id_t   task_row_id;
  row_id_t   task_prefix_id;
  logic      task_root;
  pattern_t  task_pattern;
  popcount_t task_popcount;

  pattern_t tile_model [`PPU_ROWS]; // Copy of what the host wrote

  ppu_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the run did not finish in time");
    $display("SIMULATION FAILED");
    $fatal(1);
  end

  // ==============================
  // Compare tasks
  // ==============================
  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_pattern(input string name, input pattern_t got, input pattern_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_popcount(input string name, input popcount_t got, input popcount_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_row_id(input string name, input row_id_t got, input row_id_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // ==============================
  // Reference model
  // ==============================
  // Clears the lowest set bit until nothing is left
  function automatic popcount_t spike_total(input pattern_t p);
    popcount_t n;
    pattern_t  v;
    n = '0;
    v = p;
    while (v != '0) begin
      v = v & (v - 1'b1);
      n = n + 1'b1;
    end
    return n;
  endfunction

  task automatic expect_task(input int row, output logic root, output row_id_t prefix,
                             output pattern_t pat, output popcount_t pc);
    int best;
    best = -1;
    // Downward scan, >= lets a lower index win a tie
    for (int j = row - 1; j >= 0; j--) begin
      if (spike_total(tile_model[j]) != 0
          && ((tile_model[j] | tile_model[row]) == tile_model[row])
          && (best < 0 || spike_total(tile_model[j]) >= spike_total(tile_model[best])))
        best = j;
    end
    root   = (best < 0);
    prefix = root ? row_id_t'(0) : row_id_t'(best);
    pat    = root ? tile_model[row] : (tile_model[row] ^ tile_model[best]);
    pc     = spike_total(pat);
  endtask

  // ==============================
  // Host access and pass runner
  // ==============================
  task automatic load_tile();
    for (int r = 0; r < `PPU_ROWS; r++) begin
      @(posedge clk);
      tile_wr_en   <= 1'b1;
      tile_wr_addr <= row_id_t'(r);
      tile_wr_data <= tile_model[r];
    end
    @(posedge clk);
    tile_wr_en <= 1'b0;
  endtask

  task automatic read_all_rows();
    for (int r = 0; r < `PPU_ROWS; r++) begin
      @(posedge clk);
      tile_rd_addr <= row_id_t'(r);
      @(posedge clk); // Registered readback
      @(negedge clk);
      check_pattern("tile_rd_data", tile_rd_data, tile_model[r]);
      check_popcount("popcount_rd_data", popcount_rd_data, spike_total(tile_model[r]));
    end
  endtask

  task automatic run_passes(input int passes, input bit random_ready);
    int        idx;
    int        done_seen;
    int        cycles;
    bit        held;
    row_id_t   h_row;
    row_id_t   h_prefix;
    logic      h_root;
    pattern_t  h_pat;
    popcount_t h_pc;
    logic      e_root;
    row_id_t   e_prefix;
    pattern_t  e_pat;
    popcount_t e_pc;
    idx = 0;
    done_seen = 0;
    cycles = 0;
    held = 1'b0;
    @(posedge clk);
    tile_start <= 1'b1;
    task_ready <= 1'b1;
    @(posedge clk);
    tile_start <= 1'b0;
    while (done_seen < passes) begin
      @(negedge clk);
      cycles++;
      if (cycles > passes * `PPU_ROWS * 16) abort_run("tile_done did not arrive in time");
      check_bit("ppu_busy", ppu_busy, 1'b1);
      if (held) begin // Stalled head must not move
        check_bit("task_valid", task_valid, 1'b1);
        check_row_id("task_row_id", task_row_id, h_row);
        check_row_id("task_prefix_id", task_prefix_id, h_prefix);
        check_bit("task_root", task_root, h_root);
        check_pattern("task_pattern", task_pattern, h_pat);
        check_popcount("task_popcount", task_popcount, h_pc);
      end
      held = 1'b0;
      if (task_valid) begin
        if (idx >= `PPU_ROWS) abort_run("extra task after the last row of the pass");
        if (task_ready) begin // Transfers on the next edge
          expect_task(idx, e_root, e_prefix, e_pat, e_pc);
          check_row_id("task_row_id", task_row_id, row_id_t'(idx));
          check_bit("task_root", task_root, e_root);
          check_row_id("task_prefix_id", task_prefix_id, e_prefix);
          check_pattern("task_pattern", task_pattern, e_pat);
          check_popcount("task_popcount", task_popcount, e_pc);
          idx++;
        end else begin
          held     = 1'b1;
          h_row    = task_row_id;
          h_prefix = task_prefix_id;
          h_root   = task_root;
          h_pat    = task_pattern;
          h_pc     = task_popcount;
        end
      end
      if (tile_done) begin
        if (idx != `PPU_ROWS) abort_run("tile_done came before every row had transferred");
        done_seen++;
        idx = 0; // Also catches a second pulse
      end
      @(posedge clk);
      task_ready <= random_ready ? ($urandom % 2 == 1) : 1'b1;
      if (done_seen > 0) cfg_auto_repeat <= 1'b0; // Sampled as set on the first done
    end
    @(negedge clk);
    check_bit("ppu_busy", ppu_busy, 1'b0);
    check_bit("tile_done", tile_done, 1'b0);
    check_bit("task_valid", task_valid, 1'b0);
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_reset_state();
    @(negedge clk);
    check_bit("task_valid", task_valid, 1'b0);
    check_bit("tile_done", tile_done, 1'b0);
    check_bit("ppu_busy", ppu_busy, 1'b0);
    for (int r = 0; r < `PPU_ROWS; r++) tile_model[r] = '0;
    read_all_rows();
    run_passes(1, 1'b0); // Every row a root, zero residual
  endtask

  task automatic test_write_readback();
    for (int r = 0; r < `PPU_ROWS; r++) tile_model[r] = pattern_t'($urandom);
    load_tile();
    read_all_rows();
  endtask

  task automatic test_crafted_chains();
    // Nested subsets, popcount ties, a zero row, row 6 equal to row 1
    tile_model = '{16'h0003, 16'h000F, 16'h0000, 16'h0030,
                   16'h0033, 16'h003F, 16'h000F, 16'h00FF,
                   16'h0100, 16'h0300, 16'h0F00, 16'hFFFF,
                   16'h8000, 16'h0C00, 16'hFF00, 16'h0101};
    load_tile();
    run_passes(1, 1'b0);
  endtask

  task automatic test_random_backpressure();
    // Sparse patterns give more subset hits
    for (int r = 0; r < `PPU_ROWS; r++) tile_model[r] = pattern_t'($urandom & $urandom);
    load_tile();
    run_passes(1, 1'b1);
  endtask

  task automatic test_auto_repeat();
    @(posedge clk);
    cfg_auto_repeat <= 1'b1;
    run_passes(2, 1'b0); // Same tile, same tasks twice
  endtask

  initial begin
    void'($urandom(32'h41e5e8e1));
    rst_n           = 1'b0;
    tile_wr_en      = 1'b0;
    tile_wr_addr    = '0;
    tile_wr_data    = '0;
    tile_rd_addr    = '0;
    tile_start      = 1'b0;
    cfg_auto_repeat = 1'b0;
    task_ready      = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_state();
    test_write_readback();
    test_crafted_chains();
    test_random_backpressure();
    test_auto_repeat();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- tcam_tile_store.sv
`timescale 1ns/10ps
`include "ppu_params.svh"

module tcam_tile_store import ppu_tile_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Host write port
  input  logic      tile_wr_en,
  input  row_id_t   tile_wr_addr,
  input  pattern_t  tile_wr_data,
  // Host read port
  input  row_id_t   tile_rd_addr,
  output pattern_t  tile_rd_data,
  output popcount_t popcount_rd_data,
  // Views for the match and select logic
  output pattern_t  row_patterns [`PPU_ROWS],
  output popcount_t row_popcounts [`PPU_ROWS]
);

  // ==============================
  // Tile registers
  // ==============================
  // All rows empty after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < `PPU_ROWS; r++) begin
        row_patterns[r]  <= '0;
        row_popcounts[r] <= '0;
      end
    end else if (tile_wr_en) begin
      row_patterns[tile_wr_addr]  <= tile_wr_data;
      row_popcounts[tile_wr_addr] <= count_ones(tile_wr_data); // Follows the written pattern
    end
  end

  // ==============================
  // Host readback
  // ==============================
  // Returns old data on a same-cycle write
  always_ff @(posedge clk) begin
    tile_rd_data     <= row_patterns[tile_rd_addr];
    popcount_rd_data <= row_popcounts[tile_rd_addr];
  end

endmodule

//--- tile_sequencer.sv
`timescale 1ns/10ps
`include "ppu_params.svh"

module tile_sequencer import ppu_tile_pkg::*, ppu_ctrl_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    tile_start,
  input  logic    cfg_auto_repeat,
  input  logic    issue_allow, // Dispatcher has a free slot
  input  logic    tile_done,
  output logic    issue_valid,
  output row_id_t issue_row_id,
  output logic    ppu_busy
);

  seq_state_t state;
  seq_state_t state_nxt;
  row_id_t    row_cnt; // Next row to issue
  logic       last_row;

  assign issue_valid  = (state == PROCESS) && issue_allow;
  assign issue_row_id = row_cnt;
  assign ppu_busy     = state != IDLE;
  assign last_row     = row_cnt == row_id_t'(`PPU_ROWS - 1);

  // ==============================
  // Next state
  // ==============================
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (tile_start) state_nxt = PROCESS;
      PROCESS: if (issue_valid && last_row) state_nxt = DRAIN;
      DRAIN: begin
        // Repeat decision taken at the end of each pass
        if (tile_done) state_nxt = cfg_auto_repeat ? PROCESS : IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      row_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state != PROCESS) begin
        row_cnt <= '0; // Every pass starts at row 0
      end else if (issue_valid) begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

endmodule
